//--- rtl/nocRouter_settings.svh
`ifndef NOC_ROUTER_SETTINGS_SVH
`define NOC_ROUTER_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// router port sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define NOC_PORTS       5   // L, N, E, W, S.
`define NOC_FLIT_W      16
`define NOC_TYPE_W      3   // top bits of a flit.
`define NOC_LEN_W       12  // low bits of a header.
`define NOC_QUEUE_DEPTH 4   // power of two.

`endif

//--- rtl/nocRouterPkg.sv
`include "nocRouter_settings.svh"

package nocRouterPkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flit format
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // type field, one-hot per kind.
  typedef enum logic [`NOC_TYPE_W-1:0] {flitHeader = 3'b001, flitBody = 3'b010, flitTail = 3'b100} flitKindT;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // arbiter state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Bit 0 is idle, bits 1..5 grant L, N, E, W, S.
  typedef logic [`NOC_PORTS:0] arbStateT;

endpackage

//--- rtl/flitInput.sv
`timescale 1ns/1ps
`include "nocRouter_settings.svh"

module flitInput (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`NOC_FLIT_W-1:0]     inFlit,
  input  logic                       inValid,
  input  logic                       grant,
  output logic                       inFull,
  output logic                       req,
  output logic                       sent,
  output logic [`NOC_FLIT_W-1:0]     headFlit,
  output nocRouterPkg::flitKindT     headKind,
  output logic [`NOC_LEN_W-1:0]      headLength
);
  import nocRouterPkg::*;

  localparam int PtrW = $clog2(`NOC_QUEUE_DEPTH);
  localparam logic [PtrW:0] Depth = `NOC_QUEUE_DEPTH;

  logic [`NOC_FLIT_W-1:0] mem [`NOC_QUEUE_DEPTH];
  logic [PtrW-1:0]        wrPtr;
  logic [PtrW-1:0]        rdPtr;
  logic [PtrW:0]          count;
  logic                   push;
  logic                   pop;

  assign inFull = (count == Depth);
  assign req    = (count != '0);
  assign push   = inValid && !inFull; // strobe while full is dropped.
  assign pop    = grant && req;
  assign sent   = pop;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage and pointers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wrPtr] <= inFlit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
      begin
        wrPtr <= wrPtr + 1'b1; // wraps at depth.
      end
      if (pop)
      begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head decode for the tenure timer.
  assign headFlit   = mem[rdPtr];
  assign headKind   = flitKindT'(headFlit[`NOC_FLIT_W-1 -: `NOC_TYPE_W]);
  assign headLength = headFlit[`NOC_LEN_W-1:0];

endmodule

//--- rtl/tenureTimer.sv
`timescale 1ns/1ps
`include "nocRouter_settings.svh"

module tenureTimer (
  input  logic                   clk,
  input  logic                   rst,
  input  nocRouterPkg::flitKindT headKind,
  input  logic [`NOC_LEN_W-1:0]  headLength,
  input  logic                   run,
  output logic                   timesUp
);
  import nocRouterPkg::*;

  logic [`NOC_LEN_W-1:0] tenureLen;
  logic [`NOC_LEN_W-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      tenureLen <= '0;
      count     <= '0;
    end
    else
    begin
      if (headKind == flitHeader)
      begin
        tenureLen <= headLength; // latest header wins.
      end
      if (run)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;
      end
    end
  end

  assign timesUp = (count == tenureLen);

endmodule

//--- rtl/portArbiter.sv
`timescale 1ns/1ps
`include "nocRouter_settings.svh"

module portArbiter (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [`NOC_PORTS-1:0]                  req,
  input  nocRouterPkg::flitKindT [`NOC_PORTS-1:0] headKind,
  input  logic [`NOC_PORTS-1:0][`NOC_LEN_W-1:0]  headLength,
  output logic [`NOC_PORTS-1:0]                  grant
);
  import nocRouterPkg::*;

  localparam arbStateT IdleState = arbStateT'(1);

  arbStateT              state;
  arbStateT              nextState;
  logic [`NOC_PORTS-1:0] run;
  logic [`NOC_PORTS-1:0] timesUp;

  // one-hot state that grants port p.
  function automatic arbStateT portState(input int p);
    return arbStateT'(1 << (p + 1));
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tenure timers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar p = 0; p < `NOC_PORTS; p++)
  begin : genTimer
    tenureTimer u_timer (
      .clk        (clk),
      .rst        (rst),
      .headKind   (headKind[p]),
      .headLength (headLength[p]),
      .run        (run[p]),
      .timesUp    (timesUp[p])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state register and next state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= IdleState;
    end
    else
    begin
      state <= nextState;
    end
  end

  always_comb
  begin
    nextState = IdleState; // also the way out of an illegal state.
    run       = '0;
    if (state == IdleState)
    begin
      // fixed order L, N, E, W, S. Last hit in a descending scan wins.
      for (int i = `NOC_PORTS - 1; i >= 0; i--)
      begin
        if (req[i])
        begin
          nextState = portState(i);
        end
      end
    end
    else
    begin
      for (int o = 0; o < `NOC_PORTS; o++)
      begin
        if (state == portState(o))
        begin
          if (req[o] && !timesUp[o])
          begin
            run[o]    = 1'b1; // owner keeps the output.
            nextState = state;
          end
          else
          begin
            // rotate over the other ports, nearest after the owner first.
            for (int k = `NOC_PORTS - 1; k >= 1; k--)
            begin
              if (req[(o + k) % `NOC_PORTS])
              begin
                nextState = portState((o + k) % `NOC_PORTS);
              end
            end
          end
        end
      end
    end
  end

  assign grant = state[`NOC_PORTS:1];

endmodule

//--- rtl/outputSwitch.sv
`timescale 1ns/1ps
`include "nocRouter_settings.svh"

module outputSwitch (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [`NOC_PORTS-1:0]                  sent,
  input  logic [`NOC_PORTS-1:0][`NOC_FLIT_W-1:0] headFlit,
  output logic [`NOC_FLIT_W-1:0]                 outFlit,
  output logic                                   outValid,
  output logic [`NOC_PORTS-1:0]                  outPort
);

  logic [`NOC_FLIT_W-1:0] selFlit;

  // and-or mux, sent is one-hot or zero.
  always_comb
  begin
    selFlit = '0;
    for (int p = 0; p < `NOC_PORTS; p++)
    begin
      selFlit = selFlit | ({`NOC_FLIT_W{sent[p]}} & headFlit[p]);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= |sent;
    end
  end

  always_ff @(posedge clk)
  begin
    outFlit <= selFlit;
    outPort <= sent; // source tag.
  end

endmodule

//--- rtl/nocRouterPort.sv
`timescale 1ns/1ps
`include "nocRouter_settings.svh"

module nocRouterPort (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [`NOC_PORTS-1:0][`NOC_FLIT_W-1:0] inFlit,
  input  logic [`NOC_PORTS-1:0]                  inValid,
  output logic [`NOC_PORTS-1:0]                  inFull,
  output logic [`NOC_FLIT_W-1:0]                 outFlit,
  output logic                                   outValid,
  output logic [`NOC_PORTS-1:0]                  outPort
);
  import nocRouterPkg::*;

  logic     [`NOC_PORTS-1:0]                  req;
  logic     [`NOC_PORTS-1:0]                  grant;
  logic     [`NOC_PORTS-1:0]                  sent;
  logic     [`NOC_PORTS-1:0][`NOC_FLIT_W-1:0] headFlit;
  flitKindT [`NOC_PORTS-1:0]                  headKind;
  logic     [`NOC_PORTS-1:0][`NOC_LEN_W-1:0]  headLength;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // input queues, index 0 is Local
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar p = 0; p < `NOC_PORTS; p++)
  begin : genInput
    flitInput u_flitInput (
      .clk        (clk),
      .rst        (rst),
      .inFlit     (inFlit[p]),
      .inValid    (inValid[p]),
      .grant      (grant[p]),
      .inFull     (inFull[p]),
      .req        (req[p]),
      .sent       (sent[p]),
      .headFlit   (headFlit[p]),
      .headKind   (headKind[p]),
      .headLength (headLength[p])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // arbitration and output
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  portArbiter u_portArbiter (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .headKind   (headKind),
    .headLength (headLength),
    .grant      (grant)
  );

  outputSwitch u_outputSwitch (
    .clk      (clk),
    .rst      (rst),
    .sent     (sent),
    .headFlit (headFlit),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outPort  (outPort)
  );

endmodule

//--- verification/nocRouterPort_sva.sv
`timescale 1ns/1ps
`include "nocRouter_settings.svh"

module nocRouterPortSva (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [`NOC_PORTS-1:0]                  inValid,
  input  logic [`NOC_PORTS-1:0]                  inFull,
  input  logic [`NOC_PORTS-1:0]                  grant,
  input  logic [`NOC_PORTS-1:0]                  req,
  input  nocRouterPkg::flitKindT [`NOC_PORTS-1:0] headKind,
  input  logic [`NOC_PORTS-1:0][`NOC_LEN_W-1:0]  headLength,
  input  logic                                   outValid,
  input  logic [`NOC_PORTS-1:0]                  outPort
);
  import nocRouterPkg::*;

  logic [`NOC_PORTS-1:0][`NOC_LEN_W-1:0] tenureLen;
  logic [`NOC_PORTS-1:0][`NOC_LEN_W-1:0] heldCount;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tenure bookkeeping per port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar p = 0; p < `NOC_PORTS; p++)
  begin : genTenure
    always_ff @(posedge clk)
    begin
      if (rst)
      begin
        tenureLen[p] <= '0;
        heldCount[p] <= '0;
      end
      else
      begin
        if (headKind[p] == flitHeader)
        begin
          tenureLen[p] <= headLength[p];
        end
        if (grant[p] && req[p] && heldCount[p] != tenureLen[p])
        begin
          heldCount[p] <= heldCount[p] + 1'b1;
        end
        else
        begin
          heldCount[p] <= '0;
        end
      end
    end

    // grant ends right after the tenure is used up.
    tenureEnd: assert property (@(posedge clk) disable iff (rst)
      grant[p] && heldCount[p] == tenureLen[p] |=> !grant[p])
      else $error("grant of port %0d outlived its tenure", p);
  end

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("grant is not one-hot or zero");

  tagOneHot: assert property (@(posedge clk) disable iff (rst) outValid |-> $onehot(outPort))
    else $error("outPort is not one-hot with outValid");

  noStrobeWhenFull: assert property (@(posedge clk) disable iff (rst) (inValid & inFull) == '0)
    else $error("inValid strobe while inFull is high");

endmodule

bind nocRouterPort nocRouterPortSva u_sva (
  .clk        (clk),
  .rst        (rst),
  .inValid    (inValid),
  .inFull     (inFull),
  .grant      (grant),
  .req        (req),
  .headKind   (headKind),
  .headLength (headLength),
  .outValid   (outValid),
  .outPort    (outPort)
);

//--- verification/nocRouterPortTb.sv
`timescale 1ns/1ps
`include "nocRouter_settings.svh"

module nocRouterPortTb;

  localparam int PktsPerPort = 12;
  localparam int Depth = `NOC_QUEUE_DEPTH;

  logic                                   clk;
  logic                                   rst;
  logic [`NOC_PORTS-1:0][`NOC_FLIT_W-1:0] inFlit;
  logic [`NOC_PORTS-1:0]                  inValid;
  logic [`NOC_PORTS-1:0]                  inFull;
  logic [`NOC_FLIT_W-1:0]                 outFlit;
  logic                                   outValid;
  logic [`NOC_PORTS-1:0]                  outPort;

  integer seed = 15;
  int     errCount = 0;
  int     checkCount = 0;

  // model of queues, arbiter and timers.
  logic [`NOC_FLIT_W-1:0] expQ [`NOC_PORTS][$];
  logic [`NOC_FLIT_W-1:0] mMem [`NOC_PORTS][Depth];
  int                     mWr [`NOC_PORTS];
  int                     mRd [`NOC_PORTS];
  int                     mCnt [`NOC_PORTS];
  logic [`NOC_LEN_W-1:0]  mTlen [`NOC_PORTS];
  logic [`NOC_LEN_W-1:0]  mTcnt [`NOC_PORTS];
  int                     owner;         // -1 is idle.
  logic                   expValid;
  logic [`NOC_PORTS-1:0]  expPort;
  logic [`NOC_PORTS-1:0]  expFull;

  // stimulus state.
  int pktsLeft [`NOC_PORTS];
  int flitsLeft [`NOC_PORTS];
  int bodiesLeft [`NOC_PORTS];
  int rate [`NOC_PORTS];

  nocRouterPort u_nocRouterPort (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inValid  (inValid),
    .inFull   (inFull),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outPort  (outPort)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic checkVal(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checkCount++;
    if (got !== exp)
    begin
      errCount++;
      $display("Fail at %0t: %s, got %0h, expected %0h", $time, msg, got, exp);
    end
  endtask

  // next flit of the running packet or a new header.
  function automatic logic [`NOC_FLIT_W-1:0] nextFlit(input int p);
    logic [12:0] payload;
    payload = 13'($random(seed));
    if (flitsLeft[p] == 0)
    begin
      pktsLeft[p]--;
      bodiesLeft[p] = $unsigned($random(seed)) % 4;
      flitsLeft[p] = bodiesLeft[p] + 1;
      rate[p] = 1 + $unsigned($random(seed)) % 4;
      return {3'b001, payload[12], 12'($unsigned($random(seed)) % 7)};
    end
    flitsLeft[p]--;
    if (flitsLeft[p] == 0)
    begin
      return {3'b100, payload};
    end
    return {3'b010, payload};
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // cycle model and stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk)
  begin
    logic [`NOC_PORTS-1:0] mReq;
    logic [`NOC_PORTS-1:0] done;
    logic [`NOC_PORTS-1:0] run;
    logic [`NOC_FLIT_W-1:0] hd;
    int nxt;
    int q;
    int sentP;
    if (rst)
    begin
      owner = -1;
      expValid = 1'b0;
      expPort = '0;
      expFull = '0;
      for (int p = 0; p < `NOC_PORTS; p++)
      begin
        mWr[p] = 0;
        mRd[p] = 0;
        mCnt[p] = 0;
        mTlen[p] = '0;
        mTcnt[p] = '0;
        inValid[p] <= 1'b0;
      end
    end
    else
    begin
      nxt = -1;
      run = '0;
      for (int p = 0; p < `NOC_PORTS; p++)
      begin
        mReq[p] = (mCnt[p] != 0);
        done[p] = (mTcnt[p] == mTlen[p]);
      end
      if (owner < 0)
      begin
        for (int i = 0; i < `NOC_PORTS; i++)
          if (mReq[i] && nxt < 0) nxt = i;
      end
      else if (mReq[owner] && !done[owner])
      begin
        nxt = owner;
        run[owner] = 1'b1;
      end
      else
      begin
        for (int k = 1; k < `NOC_PORTS; k++)
        begin
          q = (owner + k) % `NOC_PORTS;
          if (mReq[q] && nxt < 0) nxt = q;
        end
      end
      sentP = (owner >= 0 && mReq[owner]) ? owner : -1;
      expValid = (sentP >= 0);
      expPort = expValid ? `NOC_PORTS'(1 << sentP) : '0;
      for (int p = 0; p < `NOC_PORTS; p++)
      begin
        hd = mMem[p][mRd[p]];
        if (hd[`NOC_FLIT_W-1 -: `NOC_TYPE_W] == 3'b001) mTlen[p] = hd[`NOC_LEN_W-1:0];
        mTcnt[p] = run[p] ? mTcnt[p] + 1'b1 : '0;
        if (inValid[p] && mCnt[p] < Depth)
        begin
          mMem[p][mWr[p]] = inFlit[p];
          expQ[p].push_back(inFlit[p]);
          mWr[p] = (mWr[p] + 1) % Depth;
          mCnt[p]++;
        end
        if (p == sentP)
        begin
          mRd[p] = (mRd[p] + 1) % Depth;
          mCnt[p]--;
        end
        expFull[p] = (mCnt[p] == Depth);
        // strobe only where the queue has room at the next edge.
        inValid[p] <= 1'b0;
        if ((pktsLeft[p] > 0 || flitsLeft[p] > 0) && mCnt[p] < Depth
            && ($unsigned($random(seed)) % 4) < rate[p])
        begin
          inFlit[p] <= nextFlit(p);
          inValid[p] <= 1'b1;
        end
      end
      owner = nxt;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge clk)
  begin
    int src;
    if (rst)
    begin
      checkVal(outValid, 1'b0, "outValid during reset");
      checkVal(inFull, '0, "inFull during reset");
    end
    else
    begin
      checkVal(outValid, expValid, "outValid");
      checkVal(inFull, expFull, "inFull");
      if (outValid && expValid)
      begin
        checkVal(outPort, expPort, "source port against arbiter model");
        src = -1;
        for (int p = `NOC_PORTS - 1; p >= 0; p--)
          if (expPort[p]) src = p;
        if (src < 0 || expQ[src].size() == 0)
        begin
          errCount++;
          $display("Error at %0t: output flit with no queued flit at its source", $time);
        end
        else
        begin
          checkVal(outFlit, expQ[src].pop_front(), "flit order within source port");
        end
      end
    end
  end

  function automatic bit allDone();
    for (int p = 0; p < `NOC_PORTS; p++)
      if (pktsLeft[p] > 0 || flitsLeft[p] > 0 || expQ[p].size() != 0) return 1'b0;
    return !outValid;
  endfunction

  initial
  begin
    rst = 1'b1;
    inValid = '0;
    inFlit = '0;
    for (int p = 0; p < `NOC_PORTS; p++)
    begin
      pktsLeft[p] = PktsPerPort;
      flitsLeft[p] = 0;
      rate[p] = 1;
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    while (!allDone()) @(negedge clk);
    repeat (5) @(negedge clk);
    $display("Checks %0d, errors %0d", checkCount, errCount);
    if (errCount == 0)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog sized from the packet count.
  initial
  begin
    repeat (`NOC_PORTS * PktsPerPort * 10 + 2000) @(posedge clk);
    $display("Timeout: not every flit was delivered in time");
    $display("Checks %0d, errors %0d", checkCount, errCount);
    $display("Something failed");
    $finish;
  end

endmodule

//--- nocRouterPort.f
+incdir+rtl
rtl/nocRouterPkg.sv
rtl/flitInput.sv
rtl/tenureTimer.sv
rtl/portArbiter.sv
rtl/outputSwitch.sv
rtl/nocRouterPort.sv
verification/nocRouterPort_sva.sv
verification/nocRouterPortTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= nocRouterPortTb
FLIST     ?= nocRouterPort.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf $(OBJ_DIR)
